// ==== axi_sram_pkg.sv ====
// AXI SRAM shared definitions
package axi_sram_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_WIDTH   = 4;
  localparam int RESP_WIDTH = 2;

  // Memory geometry and address split
  localparam int IDX_WIDTH = 8;
  localparam int MEM_DEPTH = 1 << IDX_WIDTH;
  localparam int IDX_LSB   = 3;
  localparam int IDX_MSB   = IDX_LSB + IDX_WIDTH - 1;
  localparam int TAG_LSB   = IDX_MSB + 1;

  // AXI response codes
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'd2;

  // Channel FSM encodings
  localparam logic [1:0] WR_IDLE = 2'd0;
  localparam logic [1:0] WR_DATA = 2'd1;
  localparam logic [1:0] WR_RESP = 2'd2;
  localparam logic       RD_IDLE = 1'b0;
  localparam logic       RD_DATA = 1'b1;

  // Everything above the word index must be zero
  function automatic logic addr_in_range(input logic [ADDR_WIDTH-1:0] addr);
    return addr[ADDR_WIDTH-1:TAG_LSB] == '0;
  endfunction

  // Word index, byte offset dropped
  function automatic logic [IDX_WIDTH-1:0] addr_index(input logic [ADDR_WIDTH-1:0] addr);
    return addr[IDX_MSB:IDX_LSB];
  endfunction

endpackage

// ==== logic/axi_sram_bank.sv ====
// Byte-strobed SRAM bank
`timescale 1ns/10ps

module axi_sram_bank (
  input  logic                                i_aclk,

  // Write port
  input  logic                                i_we,
  input  logic [axi_sram_pkg::IDX_WIDTH-1:0]  i_widx,
  input  logic [axi_sram_pkg::DATA_WIDTH-1:0] i_wdata,
  input  logic [axi_sram_pkg::STRB_WIDTH-1:0] i_wbe,

  // Read port
  input  logic                                i_re,
  input  logic [axi_sram_pkg::IDX_WIDTH-1:0]  i_ridx,
  output logic [axi_sram_pkg::DATA_WIDTH-1:0] o_rdata
);

  import axi_sram_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  // ------------------------------------------------
  // Write side, one lane per strobe bit
  // ------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wbe[b]) begin
          mem[i_widx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------
  // Read side
  // ------------------------------------------------
  // Loads only on a read, so the word holds while the
  // R channel is stalled. Same-word collision sees old data
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_ridx];
    end
  end

endmodule

// ==== logic/axi_sram_write_ctrl.sv ====
// AXI write channel controller
`timescale 1ns/10ps

module axi_sram_write_ctrl (
  input  logic                                i_aclk,
  input  logic                                i_rst_n,

  // AW channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]   i_awid,
  input  logic [axi_sram_pkg::ADDR_WIDTH-1:0] i_awaddr,
  input  logic                                i_awvalid,
  output logic                                o_awready,

  // W channel
  input  logic [axi_sram_pkg::DATA_WIDTH-1:0] i_wdata,
  input  logic [axi_sram_pkg::STRB_WIDTH-1:0] i_wstrb,
  input  logic                                i_wlast,
  input  logic                                i_wvalid,
  output logic                                o_wready,

  // B channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]   o_bid,
  output logic [axi_sram_pkg::RESP_WIDTH-1:0] o_bresp,
  output logic                                o_bvalid,
  input  logic                                i_bready,

  // Bank write port
  output logic                                o_mem_we,
  output logic [axi_sram_pkg::IDX_WIDTH-1:0]  o_mem_idx,
  output logic [axi_sram_pkg::DATA_WIDTH-1:0] o_mem_wdata,
  output logic [axi_sram_pkg::STRB_WIDTH-1:0] o_mem_wbe
);

  import axi_sram_pkg::*;

  logic [1:0]          state;
  logic                aw_fire;
  logic                w_fire;
  logic                b_fire;
  logic [ID_WIDTH-1:0] aw_id;
  logic [IDX_WIDTH-1:0] aw_idx;
  logic                aw_ok;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;

  // ------------------------------------------------
  // IDLE -> DATA -> RESP
  // ------------------------------------------------
  // Single beat only, so i_wlast carries no extra information
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state <= WR_IDLE;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_fire) begin
            state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // Address phase capture
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_id  <= i_awid;
      aw_idx <= addr_index(i_awaddr);
      aw_ok  <= addr_in_range(i_awaddr);
    end
  end

  assign o_awready = (state == WR_IDLE);
  assign o_wready  = (state == WR_DATA);
  assign o_bvalid  = (state == WR_RESP);

  // Out-of-range writes are dropped here
  assign o_mem_we    = w_fire & aw_ok;
  assign o_mem_idx   = aw_idx;
  assign o_mem_wdata = i_wdata;
  assign o_mem_wbe   = i_wstrb;

  assign o_bid   = aw_id;
  assign o_bresp = aw_ok ? RESP_OKAY : RESP_SLVERR;

endmodule

// ==== logic/axi_sram_read_ctrl.sv ====
// AXI read channel controller
`timescale 1ns/10ps

module axi_sram_read_ctrl (
  input  logic                                i_aclk,
  input  logic                                i_rst_n,

  // AR channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]   i_arid,
  input  logic [axi_sram_pkg::ADDR_WIDTH-1:0] i_araddr,
  input  logic                                i_arvalid,
  output logic                                o_arready,

  // R channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]   o_rid,
  output logic [axi_sram_pkg::DATA_WIDTH-1:0] o_rdata,
  output logic [axi_sram_pkg::RESP_WIDTH-1:0] o_rresp,
  output logic                                o_rlast,
  output logic                                o_rvalid,
  input  logic                                i_rready,

  // Bank read port
  output logic                                o_mem_re,
  output logic [axi_sram_pkg::IDX_WIDTH-1:0]  o_mem_idx,
  input  logic [axi_sram_pkg::DATA_WIDTH-1:0] i_mem_rdata
);

  import axi_sram_pkg::*;

  logic                state;
  logic                ar_fire;
  logic                r_fire;
  logic [ID_WIDTH-1:0] ar_id;
  logic                ar_ok;

  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // ------------------------------------------------
  // IDLE -> DATA
  // ------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_fire) begin
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (r_fire) begin
            state <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      ar_id <= i_arid;
      ar_ok <= addr_in_range(i_araddr);
    end
  end

  assign o_arready = (state == RD_IDLE);
  assign o_rvalid  = (state == RD_DATA);

  // Bank word lands together with o_rvalid
  assign o_mem_re  = ar_fire;
  assign o_mem_idx = addr_index(i_araddr);

  assign o_rid   = ar_id;
  assign o_rdata = ar_ok ? i_mem_rdata : '0;
  assign o_rresp = ar_ok ? RESP_OKAY : RESP_SLVERR;
  assign o_rlast = 1'b1;

endmodule

// ==== logic/axi_sram_top.sv ====
// AXI4 SRAM slave top
`timescale 1ns/10ps

module axi_sram_top (
  input  logic                                i_aclk,
  input  logic                                i_rst_n,

  // AW channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]   i_awid,
  input  logic [axi_sram_pkg::ADDR_WIDTH-1:0] i_awaddr,
  input  logic                                i_awvalid,
  output logic                                o_awready,

  // W channel
  input  logic [axi_sram_pkg::DATA_WIDTH-1:0] i_wdata,
  input  logic [axi_sram_pkg::STRB_WIDTH-1:0] i_wstrb,
  input  logic                                i_wlast,
  input  logic                                i_wvalid,
  output logic                                o_wready,

  // B channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]   o_bid,
  output logic [axi_sram_pkg::RESP_WIDTH-1:0] o_bresp,
  output logic                                o_bvalid,
  input  logic                                i_bready,

  // AR channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]   i_arid,
  input  logic [axi_sram_pkg::ADDR_WIDTH-1:0] i_araddr,
  input  logic                                i_arvalid,
  output logic                                o_arready,

  // R channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]   o_rid,
  output logic [axi_sram_pkg::DATA_WIDTH-1:0] o_rdata,
  output logic [axi_sram_pkg::RESP_WIDTH-1:0] o_rresp,
  output logic                                o_rlast,
  output logic                                o_rvalid,
  input  logic                                i_rready
);

  import axi_sram_pkg::*;

  logic                  mem_we;
  logic [IDX_WIDTH-1:0]  mem_widx;
  logic [DATA_WIDTH-1:0] mem_wdata;
  logic [STRB_WIDTH-1:0] mem_wbe;
  logic                  mem_re;
  logic [IDX_WIDTH-1:0]  mem_ridx;
  logic [DATA_WIDTH-1:0] mem_rdata;

  // ------------------------------------------------
  // Channel controllers
  // ------------------------------------------------
  axi_sram_write_ctrl u_write_ctrl (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_awid      (i_awid),
    .i_awaddr    (i_awaddr),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wlast     (i_wlast),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bid       (o_bid),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .o_mem_we    (mem_we),
    .o_mem_idx   (mem_widx),
    .o_mem_wdata (mem_wdata),
    .o_mem_wbe   (mem_wbe)
  );

  axi_sram_read_ctrl u_read_ctrl (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_arid      (i_arid),
    .i_araddr    (i_araddr),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rid       (o_rid),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rlast     (o_rlast),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_mem_re    (mem_re),
    .o_mem_idx   (mem_ridx),
    .i_mem_rdata (mem_rdata)
  );

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------
  axi_sram_bank u_bank (
    .i_aclk  (i_aclk),
    .i_we    (mem_we),
    .i_widx  (mem_widx),
    .i_wdata (mem_wdata),
    .i_wbe   (mem_wbe),
    .i_re    (mem_re),
    .i_ridx  (mem_ridx),
    .o_rdata (mem_rdata)
  );

endmodule

// ==== verification/axi_sram_assertions.sv ====
// AXI SRAM handshake assertions
`timescale 1ns/10ps

module axi_sram_assertions (
  input logic                                i_aclk,
  input logic                                i_rst_n,
  input logic                                o_awready,
  input logic                                o_arready,
  input logic [axi_sram_pkg::ID_WIDTH-1:0]   o_bid,
  input logic [axi_sram_pkg::RESP_WIDTH-1:0] o_bresp,
  input logic                                o_bvalid,
  input logic                                i_bready,
  input logic [axi_sram_pkg::ID_WIDTH-1:0]   o_rid,
  input logic [axi_sram_pkg::DATA_WIDTH-1:0] o_rdata,
  input logic [axi_sram_pkg::RESP_WIDTH-1:0] o_rresp,
  input logic                                o_rvalid,
  input logic                                i_rready
);

  // Stalled responses keep valid and payload
  b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp))
    else $error("B response changed while stalled");

  r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=>
      o_rvalid && $stable(o_rid) && $stable(o_rdata) && $stable(o_rresp))
    else $error("R response changed while stalled");

  // Both sides idle right out of reset
  reset_state: assert property (@(posedge i_aclk)
    $rose(i_rst_n) |-> o_awready && o_arready && !o_bvalid && !o_rvalid)
    else $error("Channels not idle in the first cycle after reset");

endmodule

bind axi_sram_top axi_sram_assertions u_assert (.*);

// ==== verification/tb_axi_sram.sv ====
// AXI SRAM testbench
`timescale 1ns/10ps

module tb_axi_sram;

  import axi_sram_pkg::*;

  localparam int TIMEOUT_CYCLES = 32;

  logic                  i_aclk = 1'b0;
  logic                  i_rst_n;
  logic [ID_WIDTH-1:0]   i_awid, i_arid, o_bid, o_rid;
  logic [ADDR_WIDTH-1:0] i_awaddr, i_araddr;
  logic [DATA_WIDTH-1:0] i_wdata, o_rdata;
  logic [STRB_WIDTH-1:0] i_wstrb;
  logic [RESP_WIDTH-1:0] o_bresp, o_rresp;
  logic                  i_awvalid, i_wvalid, i_wlast, i_bready, i_arvalid, i_rready;
  logic                  o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_rlast;
  string                 test_name;
  int                    waited;

  axi_sram_top dut_i (.*);

  always #2 i_aclk = ~i_aclk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_with_failure($sformatf("Fail %s %s expected %0h actual %0h",
                                  test_name, what, exp, act));
    end
  endtask

  // Inputs change and outputs are sampled 1 ns after the edge
  task automatic next_cycle();
    @(posedge i_aclk);
    #1;
  endtask

  task automatic tick_with_timeout(input string chan);
    waited++;
    if (waited > TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout in %s waiting on the %s channel", test_name, chan));
    end
    next_cycle();
  endtask

  task automatic write_word(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data,
                            input logic [STRB_WIDTH-1:0] strb,
                            input logic [RESP_WIDTH-1:0] resp);
    int hold;
    i_awid    = id;
    i_awaddr  = addr;
    i_awvalid = 1'b1;
    waited    = 0;
    while (!o_awready) begin
      tick_with_timeout("AW");
    end
    check_value("wready before AW", 64'(1'b0), 64'(o_wready));
    next_cycle();
    // Data phase opens one cycle after AW
    check_value("wready after AW", 64'(1'b1), 64'(o_wready));
    check_value("awready after AW", 64'(1'b0), 64'(o_awready));
    i_awvalid = 1'b0;
    i_wdata   = data;
    i_wstrb   = strb;
    i_wvalid  = 1'b1;
    check_value("bvalid before W", 64'(1'b0), 64'(o_bvalid));
    next_cycle();
    i_wvalid = 1'b0;
    // B is due one cycle after W and holds while bready is low
    hold = $urandom % 4;
    for (int k = 0; k <= hold; k++) begin
      check_value("bvalid", 64'(1'b1), 64'(o_bvalid));
      check_value("bid", 64'(id), 64'(o_bid));
      check_value("bresp", 64'(resp), 64'(o_bresp));
      i_bready = (k == hold);
      next_cycle();
    end
    i_bready = 1'b0;
    check_value("awready after B", 64'(1'b1), 64'(o_awready));
  endtask

  task automatic read_word(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [RESP_WIDTH-1:0] resp,
                           input logic [DATA_WIDTH-1:0] data);
    int hold;
    i_arid    = id;
    i_araddr  = addr;
    i_arvalid = 1'b1;
    waited    = 0;
    while (!o_arready) begin
      tick_with_timeout("AR");
    end
    check_value("rvalid before AR", 64'(1'b0), 64'(o_rvalid));
    next_cycle();
    i_arvalid = 1'b0;
    // R due one cycle after AR
    hold = $urandom % 4;
    for (int k = 0; k <= hold; k++) begin
      check_value("rvalid", 64'(1'b1), 64'(o_rvalid));
      check_value("rlast", 64'(1'b1), 64'(o_rlast));
      check_value("rid", 64'(id), 64'(o_rid));
      check_value("rresp", 64'(resp), 64'(o_rresp));
      check_value("rdata", data, o_rdata);
      i_rready = (k == hold);
      next_cycle();
    end
    i_rready = 1'b0;
    check_value("arready after R", 64'(1'b1), 64'(o_arready));
  endtask

  initial begin
    int                    fd;
    int                    line_no;
    int                    fields;
    string                 line;
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic [RESP_WIDTH-1:0] resp;
    logic [DATA_WIDTH-1:0] exp_data;
    void'($urandom(63230));
    i_rst_n = 1'b0;
    i_wlast = 1'b1;
    {i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready} = '0;
    {i_awid, i_awaddr, i_wdata, i_wstrb, i_arid, i_araddr} = '0;
    repeat (4) @(posedge i_aclk);
    #1;
    i_rst_n   = 1'b1;
    test_name = "reset";
    check_value("awready arready bvalid rvalid", 64'(4'b1100),
                64'({o_awready, o_arready, o_bvalid, o_rvalid}));
    fd = $fopen("verification/axi_sram_golden.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open verification/axi_sram_golden.txt");
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line_no++;
      if ($fgets(line, fd) == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                       id, addr, data, strb, resp, exp_data);
      if (fields != 6) begin
        stop_with_failure($sformatf("Malformed golden line %0d", line_no));
      end
      test_name = $sformatf("golden line %0d", line_no);
      if (line.getc(0) == "W") begin
        write_word(id, addr, data, strb, resp);
      end else if (line.getc(0) == "R") begin
        read_word(id, addr, resp, exp_data);
      end else begin
        stop_with_failure($sformatf("Unknown operation on golden line %0d", line_no));
      end
    end
    $fclose(fd);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== verification/axi_sram_golden.txt ====
# op id addr data strb resp rdata, all values in hex
# op is W or R; data and strb unused on R, rdata unused on W
W 1 00000000 0123456789abcdef ff 0 0
W 2 00000008 fedcba9876543210 ff 0 0
W 3 000007f8 a5a5a5a5a5a5a5a5 ff 0 0
R 4 00000000 0 0 0 0123456789abcdef
R 5 00000008 0 0 0 fedcba9876543210
R 6 000007f8 0 0 0 a5a5a5a5a5a5a5a5
W 7 00000000 1111111111111111 0f 0 0
R 8 00000000 0 0 0 0123456711111111
W 9 00000008 2222222222222222 a5 0 0
R a 0000000c 0 0 0 22dc229876223222
W b 000007fd 5a5a5a5a5a5a5a5a 01 0 0
R c 000007f8 0 0 0 a5a5a5a5a5a5a55a
W d 00000800 deadbeefdeadbeef ff 2 0
R e 00000800 0 0 2 0
R f 00000000 0 0 0 0123456711111111
W 0 80000008 cafef00dcafef00d ff 2 0
R 1 00000008 0 0 0 22dc229876223222
R 2 fffffff8 0 0 2 0
W 3 00000010 0f0f0f0f0f0f0f0f ff 0 0
R 4 00000010 0 0 0 0f0f0f0f0f0f0f0f

// ==== tb.f ====
axi_sram_pkg.sv
logic/axi_sram_bank.sv
logic/axi_sram_write_ctrl.sv
logic/axi_sram_read_ctrl.sv
logic/axi_sram_top.sv
verification/axi_sram_assertions.sv
verification/tb_axi_sram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI SRAM testbench with Verilator
verilator --binary --assert --timescale 1ns/10ps -f tb.f --top-module tb_axi_sram \
  -o sim_axi_sram \
  && ./obj_dir/sim_axi_sram | tee sim.log \
  && grep -qF "*** PASSED ***" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
